// ==== gpu_settings.svh ====
`ifndef GPU_SETTINGS_SVH
`define GPU_SETTINGS_SVH

// Core shape
`define WARPS_PER_CORE 4
`define THREADS_PER_WARP 4

// Word width of registers and data memory
`define DATA_WIDTH 32

// Registers per thread with register 0 reading as zero
`define REG_COUNT 16

// Memory address widths
`define IMEM_ADDR_WIDTH 8
`define DMEM_ADDR_WIDTH 8

`endif

// ==== gpu_isa_pkg.sv ====
`include "gpu_settings.svh"

package gpu_isa_pkg;

    typedef logic [`DATA_WIDTH-1:0] data_t;
    typedef logic [31:0] instruction_t;
    typedef logic [3:0] reg_addr_t;

    // Top nibble of the instruction word with 6 to 15 left undefined
    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_ADDI  = 4'h2,
        OP_LANE  = 4'h3,
        OP_STORE = 4'h4,
        OP_HALT  = 4'h5
    } opcode_t;

    // Layout is opcode, rd, rs1, rs2, imm16
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        data_t     imm;
        logic      is_store;
        logic      writes_reg;
        logic      is_halt;
    } decoded_instr_t;

endpackage

// ==== gpu_core_pkg.sv ====
`include "gpu_settings.svh"

package gpu_core_pkg;

    typedef logic [1:0] warp_id_t;
    typedef logic [1:0] lane_id_t;
    typedef logic [`IMEM_ADDR_WIDTH-1:0] imem_addr_t;
    typedef logic [`DMEM_ADDR_WIDTH-1:0] dmem_addr_t;
    typedef logic [2:0] warp_count_t;

    typedef enum logic [2:0] {
        WARP_IDLE,
        WARP_FETCH,
        WARP_READY,
        WARP_STORE_WAIT,
        WARP_DONE
    } warp_state_t;

    // Round-robin pick of the first requester at or after ptr
    function automatic warp_id_t rr_pick(input logic [`WARPS_PER_CORE-1:0] req,
                                         input warp_id_t ptr);
        warp_id_t pick;
        warp_id_t cand;
        pick = ptr;
        // Walk backwards so the candidate closest to ptr wins
        for (int i = `WARPS_PER_CORE - 1; i >= 0; i--) begin
            cand = warp_id_t'(ptr + i);
            if (req[cand]) begin
                pick = cand;
            end
        end
        return pick;
    endfunction

endpackage

// ==== gpu_interfaces.sv ====
`timescale 1ns/1ns
`include "gpu_settings.svh"

// Scheduler requests instructions, fetcher returns them tagged by warp
interface fetch_if;
    logic [`WARPS_PER_CORE-1:0] fetch_pending;
    gpu_core_pkg::imem_addr_t   pc [`WARPS_PER_CORE];
    logic                       fetch_done;
    gpu_core_pkg::warp_id_t     fetch_warp;
    gpu_isa_pkg::instruction_t  fetch_instruction;

    modport scheduler (
        output fetch_pending, pc,
        input  fetch_done, fetch_warp, fetch_instruction
    );

    modport fetcher (
        input  fetch_pending, pc,
        output fetch_done, fetch_warp, fetch_instruction
    );
endinterface

// Broadcast of the issued instruction to every lane and the store drain
interface lane_issue_if;
    logic                        issue;
    gpu_core_pkg::warp_id_t      issue_warp;
    gpu_isa_pkg::decoded_instr_t issue_instr;

    modport scheduler (output issue, issue_warp, issue_instr);
    modport lane (input issue, issue_warp, issue_instr);
    modport drain (input issue, issue_instr);
endinterface

// Captured store words, one slot per lane
interface store_bus_if;
    gpu_core_pkg::dmem_addr_t store_address [`THREADS_PER_WARP];
    gpu_isa_pkg::data_t       store_data [`THREADS_PER_WARP];
    logic                     busy;
    logic                     store_done;

    modport lane (output store_address, store_data);
    modport drain (input store_address, store_data, output busy, store_done);
    modport monitor (input busy, store_done);
endinterface

// ==== instruction_decoder.sv ====
`timescale 1ns/1ns

module instruction_decoder (
    input  gpu_isa_pkg::instruction_t   instr,
    output gpu_isa_pkg::decoded_instr_t decoded
);

    always_comb begin
        decoded.opcode = gpu_isa_pkg::opcode_t'(instr[31:28]);
        decoded.rd = instr[27:24];
        decoded.rs1 = instr[23:20];
        decoded.rs2 = instr[19:16];
        decoded.imm = {{(`DATA_WIDTH-16){instr[15]}}, instr[15:0]};
        decoded.is_store = 1'b0;
        decoded.writes_reg = 1'b0;
        decoded.is_halt = 1'b0;
        case (instr[31:28])
            gpu_isa_pkg::OP_ADD,
            gpu_isa_pkg::OP_SUB,
            gpu_isa_pkg::OP_ADDI,
            gpu_isa_pkg::OP_LANE: decoded.writes_reg = 1'b1;
            gpu_isa_pkg::OP_STORE: decoded.is_store = 1'b1;
            // HALT and every undefined opcode retire the warp
            default: decoded.is_halt = 1'b1;
        endcase
    end

endmodule

// ==== instruction_fetcher.sv ====
`timescale 1ns/1ns
`include "gpu_settings.svh"

module instruction_fetcher (
    input  logic                       clk,
    input  logic                       reset,
    fetch_if.fetcher                   fetch,
    input  logic                       imem_read_ready,
    input  gpu_isa_pkg::instruction_t  imem_read_data,
    output logic                       imem_read_valid,
    output gpu_core_pkg::imem_addr_t   imem_read_address
);

    gpu_core_pkg::warp_id_t rr_ptr;
    gpu_core_pkg::warp_id_t pick;
    logic launch;

    assign pick = gpu_core_pkg::rr_pick(fetch.fetch_pending, rr_ptr);

    // Only one request in flight and no launch in the done pulse cycle
    assign launch = !imem_read_valid && !fetch.fetch_done && (|fetch.fetch_pending);

    always_ff @(posedge clk) begin
        if (reset) begin
            imem_read_valid <= 1'b0;
            fetch.fetch_done <= 1'b0;
            rr_ptr <= '0;
        end else begin
            fetch.fetch_done <= imem_read_valid && imem_read_ready;
            if (imem_read_valid) begin
                if (imem_read_ready) begin
                    imem_read_valid <= 1'b0;
                end
            end else if (launch) begin
                imem_read_valid <= 1'b1;
                rr_ptr <= pick + 2'd1;
            end
        end
    end

    // Address and warp tag hold steady for the whole request
    always_ff @(posedge clk) begin
        if (launch) begin
            fetch.fetch_warp <= pick;
            imem_read_address <= fetch.pc[pick];
        end
        if (imem_read_valid && imem_read_ready) begin
            fetch.fetch_instruction <= imem_read_data;
        end
    end

endmodule

// ==== warp_scheduler.sv ====
`timescale 1ns/1ns
`include "gpu_settings.svh"

module warp_scheduler (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  gpu_core_pkg::warp_count_t  num_warps,
    fetch_if.scheduler                 fetch,
    lane_issue_if.scheduler            iss,
    store_bus_if.monitor               st,
    output logic                       done
);

    gpu_core_pkg::warp_state_t   state [`WARPS_PER_CORE];
    gpu_core_pkg::imem_addr_t    pc [`WARPS_PER_CORE];
    gpu_isa_pkg::decoded_instr_t instr [`WARPS_PER_CORE];
    gpu_isa_pkg::decoded_instr_t fetched_decoded;
    gpu_core_pkg::warp_id_t      issue_ptr;
    gpu_core_pkg::warp_id_t      issue_sel;
    logic [`WARPS_PER_CORE-1:0]  eligible;
    logic running;
    logic any_done;
    logic start_ok;

    instruction_decoder u_decoder (
        .instr(fetch.fetch_instruction),
        .decoded(fetched_decoded)
    );

    always_comb begin
        running = 1'b0;
        any_done = 1'b0;
        for (int i = 0; i < `WARPS_PER_CORE; i++) begin
            fetch.fetch_pending[i] = (state[i] == gpu_core_pkg::WARP_FETCH);
            fetch.pc[i] = pc[i];
            // A store waits here while the drain still owns the lane slots
            eligible[i] = (state[i] == gpu_core_pkg::WARP_READY) &&
                          !(instr[i].is_store && st.busy);
            if (state[i] == gpu_core_pkg::WARP_FETCH ||
                state[i] == gpu_core_pkg::WARP_READY ||
                state[i] == gpu_core_pkg::WARP_STORE_WAIT) begin
                running = 1'b1;
            end
            if (state[i] == gpu_core_pkg::WARP_DONE) begin
                any_done = 1'b1;
            end
        end
    end

    assign start_ok = start && !running && (num_warps != '0) &&
                      (num_warps <= gpu_core_pkg::warp_count_t'(`WARPS_PER_CORE));

    assign issue_sel = gpu_core_pkg::rr_pick(eligible, issue_ptr);

    // Issue is combinational so lanes and warp state update on the same edge
    assign iss.issue = |eligible;
    assign iss.issue_warp = issue_sel;
    assign iss.issue_instr = instr[issue_sel];

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
            issue_ptr <= '0;
            for (int i = 0; i < `WARPS_PER_CORE; i++) begin
                state[i] <= gpu_core_pkg::WARP_IDLE;
                pc[i] <= '0;
            end
        end else if (start_ok) begin
            done <= 1'b0;
            for (int i = 0; i < `WARPS_PER_CORE; i++) begin
                state[i] <= (gpu_core_pkg::warp_count_t'(i) < num_warps) ?
                            gpu_core_pkg::WARP_FETCH : gpu_core_pkg::WARP_IDLE;
                pc[i] <= '0;
            end
        end else begin
            done <= !running && any_done;
            if (fetch.fetch_done) begin
                state[fetch.fetch_warp] <= gpu_core_pkg::WARP_READY;
            end
            if (iss.issue) begin
                issue_ptr <= issue_sel + 2'd1;
                if (instr[issue_sel].is_halt) begin
                    state[issue_sel] <= gpu_core_pkg::WARP_DONE;
                end else if (instr[issue_sel].is_store) begin
                    state[issue_sel] <= gpu_core_pkg::WARP_STORE_WAIT;
                end else begin
                    state[issue_sel] <= gpu_core_pkg::WARP_FETCH;
                    pc[issue_sel] <= pc[issue_sel] + 1'b1;
                end
            end
            // At most one warp can be waiting on the drain
            if (st.store_done) begin
                for (int i = 0; i < `WARPS_PER_CORE; i++) begin
                    if (state[i] == gpu_core_pkg::WARP_STORE_WAIT) begin
                        state[i] <= gpu_core_pkg::WARP_FETCH;
                        pc[i] <= pc[i] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.fetch_done) begin
            instr[fetch.fetch_warp] <= fetched_decoded;
        end
    end

endmodule

// ==== thread_lane.sv ====
`timescale 1ns/1ns
`include "gpu_settings.svh"

module thread_lane #(
    parameter gpu_core_pkg::lane_id_t LANE_ID = '0
) (
    input  logic        clk,
    input  logic        reset,
    lane_issue_if.lane  iss,
    store_bus_if.lane   st
);

    // One register file per warp
    gpu_isa_pkg::data_t regs [`WARPS_PER_CORE][`REG_COUNT];
    gpu_isa_pkg::data_t rs1_val;
    gpu_isa_pkg::data_t rs2_val;
    gpu_isa_pkg::data_t result;
    gpu_core_pkg::dmem_addr_t addr_q;
    gpu_isa_pkg::data_t data_q;

    assign rs1_val = (iss.issue_instr.rs1 == '0) ? '0 :
                     regs[iss.issue_warp][iss.issue_instr.rs1];
    assign rs2_val = (iss.issue_instr.rs2 == '0) ? '0 :
                     regs[iss.issue_warp][iss.issue_instr.rs2];

    always_comb begin
        case (iss.issue_instr.opcode)
            gpu_isa_pkg::OP_ADD: result = rs1_val + rs2_val;
            gpu_isa_pkg::OP_SUB: result = rs1_val - rs2_val;
            gpu_isa_pkg::OP_ADDI: result = rs1_val + iss.issue_instr.imm;
            // LANE gives the global thread id
            default: result = gpu_isa_pkg::data_t'(iss.issue_warp) *
                              gpu_isa_pkg::data_t'(`THREADS_PER_WARP) +
                              gpu_isa_pkg::data_t'(LANE_ID);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset && iss.issue && iss.issue_instr.writes_reg &&
            iss.issue_instr.rd != '0) begin
            regs[iss.issue_warp][iss.issue_instr.rd] <= result;
        end
        if (!reset && iss.issue && iss.issue_instr.is_store) begin
            addr_q <= gpu_core_pkg::dmem_addr_t'(rs1_val + iss.issue_instr.imm);
            data_q <= rs2_val;
        end
    end

    assign st.store_address[LANE_ID] = addr_q;
    assign st.store_data[LANE_ID] = data_q;

endmodule

// ==== store_drain.sv ====
`timescale 1ns/1ns
`include "gpu_settings.svh"

module store_drain (
    input  logic                      clk,
    input  logic                      reset,
    lane_issue_if.drain               iss,
    store_bus_if.drain                st,
    output logic                      dmem_write_valid,
    output gpu_core_pkg::dmem_addr_t  dmem_write_address,
    output gpu_isa_pkg::data_t        dmem_write_data,
    input  logic                      dmem_write_ready
);

    gpu_core_pkg::lane_id_t lane_cnt;
    logic last_lane;

    assign last_lane = (lane_cnt == gpu_core_pkg::lane_id_t'(`THREADS_PER_WARP - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            st.busy <= 1'b0;
            st.store_done <= 1'b0;
            lane_cnt <= '0;
        end else begin
            st.store_done <= 1'b0;
            if (!st.busy) begin
                if (iss.issue && iss.issue_instr.is_store) begin
                    st.busy <= 1'b1;
                    lane_cnt <= '0;
                end
            end else if (dmem_write_ready) begin
                if (last_lane) begin
                    st.busy <= 1'b0;
                    st.store_done <= 1'b1;
                end else begin
                    lane_cnt <= lane_cnt + 2'd1;
                end
            end
        end
    end

    // Lane slots are stable while busy, so the write payload is a plain mux
    assign dmem_write_valid = st.busy;
    assign dmem_write_address = st.store_address[lane_cnt];
    assign dmem_write_data = st.store_data[lane_cnt];

endmodule

// ==== gpu_core.sv ====
`timescale 1ns/1ns
`include "gpu_settings.svh"

module gpu_core (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  gpu_core_pkg::warp_count_t  num_warps,
    output logic                       done,
    input  logic                       imem_read_ready,
    input  gpu_isa_pkg::instruction_t  imem_read_data,
    output logic                       imem_read_valid,
    output gpu_core_pkg::imem_addr_t   imem_read_address,
    output logic                       dmem_write_valid,
    output gpu_core_pkg::dmem_addr_t   dmem_write_address,
    output gpu_isa_pkg::data_t         dmem_write_data,
    input  logic                       dmem_write_ready
);

    fetch_if      fetch_bus ();
    lane_issue_if issue_bus ();
    store_bus_if  store_bus ();

    warp_scheduler u_scheduler (
        .clk(clk),
        .reset(reset),
        .start(start),
        .num_warps(num_warps),
        .fetch(fetch_bus.scheduler),
        .iss(issue_bus.scheduler),
        .st(store_bus.monitor),
        .done(done)
    );

    instruction_fetcher u_fetcher (
        .clk(clk),
        .reset(reset),
        .fetch(fetch_bus.fetcher),
        .imem_read_ready(imem_read_ready),
        .imem_read_data(imem_read_data),
        .imem_read_valid(imem_read_valid),
        .imem_read_address(imem_read_address)
    );

    for (genvar i = 0; i < `THREADS_PER_WARP; i++) begin : g_lane
        thread_lane #(
            .LANE_ID(gpu_core_pkg::lane_id_t'(i))
        ) u_lane (
            .clk(clk),
            .reset(reset),
            .iss(issue_bus.lane),
            .st(store_bus.lane)
        );
    end

    store_drain u_drain (
        .clk(clk),
        .reset(reset),
        .iss(issue_bus.drain),
        .st(store_bus.drain),
        .dmem_write_valid(dmem_write_valid),
        .dmem_write_address(dmem_write_address),
        .dmem_write_data(dmem_write_data),
        .dmem_write_ready(dmem_write_ready)
    );

endmodule

// ==== gpu_core_props.sv ====
`timescale 1ns/1ns

module gpu_core_props (
    input logic                      clk,
    input logic                      reset,
    input logic                      done,
    input logic                      imem_read_valid,
    input logic                      imem_read_ready,
    input gpu_core_pkg::imem_addr_t  imem_read_address,
    input logic                      dmem_write_valid,
    input logic                      dmem_write_ready,
    input gpu_core_pkg::dmem_addr_t  dmem_write_address,
    input gpu_isa_pkg::data_t        dmem_write_data
);

    // Fetch request holds until the memory takes it
    imem_hold: assert property (@(posedge clk) disable iff (reset)
        imem_read_valid && !imem_read_ready |=>
            imem_read_valid && $stable(imem_read_address))
        else $error("instruction read request changed before ready");

    // Write request holds address and data until accepted
    dmem_hold: assert property (@(posedge clk) disable iff (reset)
        dmem_write_valid && !dmem_write_ready |=>
            dmem_write_valid && $stable(dmem_write_address) && $stable(dmem_write_data))
        else $error("data write request changed before ready");

    reset_idle: assert property (@(posedge clk)
        reset |=> !done && !imem_read_valid && !dmem_write_valid)
        else $error("done or a valid output high after reset");

endmodule

bind gpu_core gpu_core_props u_props (
    .clk(clk),
    .reset(reset),
    .done(done),
    .imem_read_valid(imem_read_valid),
    .imem_read_ready(imem_read_ready),
    .imem_read_address(imem_read_address),
    .dmem_write_valid(dmem_write_valid),
    .dmem_write_ready(dmem_write_ready),
    .dmem_write_address(dmem_write_address),
    .dmem_write_data(dmem_write_data)
);

// ==== gpu_core_tb.sv ====
`timescale 1ns/1ns
`include "gpu_settings.svh"

module gpu_core_tb;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS = 4;
    localparam int PROG_LEN = 24;
    localparam int BODY_LEN = 16;
    localparam int LATENCY_BOUND = 40;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * PROG_LEN * LATENCY_BOUND + RESET_CYCLES;
    localparam int IMEM_WORDS = 1 << `IMEM_ADDR_WIDTH;
    localparam int DMEM_WORDS = 1 << `DMEM_ADDR_WIDTH;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic start = 1'b0;
    gpu_core_pkg::warp_count_t num_warps = '0;
    logic done;
    logic imem_read_ready = 1'b0;
    gpu_isa_pkg::instruction_t imem_read_data = '0;
    logic imem_read_valid;
    gpu_core_pkg::imem_addr_t imem_read_address;
    logic dmem_write_valid;
    gpu_core_pkg::dmem_addr_t dmem_write_address;
    gpu_isa_pkg::data_t dmem_write_data;
    logic dmem_write_ready = 1'b0;

    integer seed = 96;
    int value_errors = 0;
    int other_errors = 0;
    logic [31:0] imem_rand;
    logic [31:0] dmem_rand;

    gpu_isa_pkg::instruction_t imem [IMEM_WORDS];
    // Expected data memory contents from the reference model
    logic exp_valid [DMEM_WORDS];
    gpu_isa_pkg::data_t exp_data [DMEM_WORDS];
    // Every accepted write, in order
    gpu_core_pkg::dmem_addr_t log_addr [$];
    gpu_isa_pkg::data_t log_data [$];

    gpu_core UUT (
        .clk(clk),
        .reset(reset),
        .start(start),
        .num_warps(num_warps),
        .done(done),
        .imem_read_ready(imem_read_ready),
        .imem_read_data(imem_read_data),
        .imem_read_valid(imem_read_valid),
        .imem_read_address(imem_read_address),
        .dmem_write_valid(dmem_write_valid),
        .dmem_write_address(dmem_write_address),
        .dmem_write_data(dmem_write_data),
        .dmem_write_ready(dmem_write_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Instruction memory answers with a random latency once it sees a request
    always @(posedge clk) begin
        imem_rand = $random(seed);
        if (imem_read_valid && !imem_read_ready) begin
            imem_read_ready <= imem_rand[0];
            imem_read_data <= imem[imem_read_address];
        end else begin
            imem_read_ready <= 1'b0;
        end
    end

    // Data memory records each accepted write
    always @(posedge clk) begin
        dmem_rand = $random(seed);
        if (dmem_write_valid && dmem_write_ready) begin
            log_addr.push_back(dmem_write_address);
            log_data.push_back(dmem_write_data);
        end
        // Ready roughly three cycles in four
        dmem_write_ready <= dmem_rand[0] | dmem_rand[1];
    end

    function automatic gpu_isa_pkg::instruction_t encode_instr(input logic [3:0] op,
                                                               input logic [3:0] rd,
                                                               input logic [3:0] rs1,
                                                               input logic [3:0] rs2,
                                                               input logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    // A register the program has not written yet is replaced by r1
    function automatic logic [3:0] source_reg(input logic [15:0] written,
                                              input logic [2:0] sel);
        return written[sel] ? {1'b0, sel} : 4'd1;
    endfunction

    task automatic make_program(input bit undef_end);
        logic [31:0] r;
        logic [3:0] rd;
        logic [3:0] src;
        logic [3:0] src2;
        logic [3:0] data_src;
        logic [3:0] bad_op;
        logic [15:0] written;
        int pc;
        int k;
        // Unused words are HALTs that carry their own address
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {4'h5, 28'(i)};
        end
        // r1 holds the thread id and store k goes to r1 + k*16
        imem[0] = encode_instr(gpu_isa_pkg::OP_LANE, 4'd1, 4'd0, 4'd0, 16'd0);
        imem[1] = encode_instr(gpu_isa_pkg::OP_STORE, 4'd0, 4'd1, 4'd1, 16'd0);
        written = 16'h0003;
        pc = 2;
        k = 1;
        for (int n = 0; n < BODY_LEN; n++) begin
            r = $random(seed);
            rd = {1'b0, r[2:0]};
            if (rd < 4'd2) begin
                rd = rd + 4'd4;
            end
            src = source_reg(written, r[6:4]);
            src2 = source_reg(written, r[14:12]);
            if (r[10:9] == 2'b11 && k < 16) begin
                data_src = source_reg(written, rd[2:0]);
                imem[pc] = encode_instr(gpu_isa_pkg::OP_STORE, 4'd0, 4'd1, data_src,
                                        16'(k * 16));
                k++;
            end else begin
                case (r[9:8])
                    2'd0: imem[pc] = encode_instr(gpu_isa_pkg::OP_ADD, rd, src, src2, 16'd0);
                    2'd1: imem[pc] = encode_instr(gpu_isa_pkg::OP_SUB, rd, src, src2, 16'd0);
                    2'd2: imem[pc] = encode_instr(gpu_isa_pkg::OP_ADDI, rd, src, 4'd0, r[31:16]);
                    default: imem[pc] = encode_instr(gpu_isa_pkg::OP_LANE, rd, 4'd0, 4'd0, 16'd0);
                endcase
                written[rd] = 1'b1;
            end
            pc++;
        end
        if (undef_end) begin
            r = $random(seed);
            bad_op = 4'd6 + {1'b0, r[2:0]};
            imem[pc] = {bad_op, 28'h0};
            // A write from this unreachable store means the warp kept running
            imem[pc + 1] = encode_instr(gpu_isa_pkg::OP_STORE, 4'd0, 4'd1, 4'd2, 16'(k * 16));
        end else begin
            imem[pc] = encode_instr(gpu_isa_pkg::OP_HALT, 4'd0, 4'd0, 4'd0, 16'd0);
        end
    endtask

    // Runs every active thread over its own register array
    task automatic run_model(input int nw);
        gpu_isa_pkg::data_t regs [`REG_COUNT];
        gpu_isa_pkg::instruction_t ins;
        gpu_isa_pkg::data_t a;
        gpu_isa_pkg::data_t b;
        gpu_isa_pkg::data_t imm;
        gpu_isa_pkg::data_t res;
        gpu_core_pkg::dmem_addr_t addr;
        logic wr_en;
        logic halted;
        int pc;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            exp_valid[i] = 1'b0;
            exp_data[i] = '0;
        end
        for (int w = 0; w < nw; w++) begin
            for (int l = 0; l < `THREADS_PER_WARP; l++) begin
                for (int i = 0; i < `REG_COUNT; i++) begin
                    regs[i] = '0;
                end
                pc = 0;
                halted = 1'b0;
                while (!halted && pc < PROG_LEN) begin
                    ins = imem[pc];
                    a = regs[ins[23:20]];
                    b = regs[ins[19:16]];
                    imm = {{(`DATA_WIDTH - 16){ins[15]}}, ins[15:0]};
                    res = '0;
                    wr_en = 1'b1;
                    case (ins[31:28])
                        4'h0: res = a + b;
                        4'h1: res = a - b;
                        4'h2: res = a + imm;
                        4'h3: res = gpu_isa_pkg::data_t'(w * `THREADS_PER_WARP + l);
                        4'h4: begin
                            wr_en = 1'b0;
                            addr = gpu_core_pkg::dmem_addr_t'(a + imm);
                            exp_valid[addr] = 1'b1;
                            exp_data[addr] = b;
                        end
                        default: begin
                            wr_en = 1'b0;
                            halted = 1'b1;
                        end
                    endcase
                    if (wr_en && ins[27:24] != 4'd0) begin
                        regs[ins[27:24]] = res;
                    end
                    pc++;
                end
            end
        end
    endtask

    task automatic check_results(input string name, input int nw, input int first_entry);
        int count [DMEM_WORDS];
        gpu_isa_pkg::data_t value [DMEM_WORDS];
        int expect_count;
        int tid;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            count[i] = 0;
            value[i] = '0;
        end
        for (int i = first_entry; i < log_addr.size(); i++) begin
            count[log_addr[i]]++;
            value[log_addr[i]] = log_data[i];
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            expect_count = exp_valid[i] ? 1 : 0;
            if (count[i] != expect_count) begin
                $display("FAILED %s write count at address %0d: expected %0d, actual %0d",
                         name, i, expect_count, count[i]);
                value_errors++;
            end else if (exp_valid[i] && value[i] != exp_data[i]) begin
                $display("FAILED %s data at address %0d: expected %h, actual %h",
                         name, i, exp_data[i], value[i]);
                value_errors++;
            end
        end
        // Thread ids follow from warp and lane alone
        for (int w = 0; w < nw; w++) begin
            for (int l = 0; l < `THREADS_PER_WARP; l++) begin
                tid = w * `THREADS_PER_WARP + l;
                if (value[tid] != gpu_isa_pkg::data_t'(tid)) begin
                    $display("FAILED %s thread id at address %0d: expected %h, actual %h",
                             name, tid, gpu_isa_pkg::data_t'(tid), value[tid]);
                    value_errors++;
                end
            end
        end
    endtask

    task automatic run_test(input string name, input gpu_core_pkg::warp_count_t nw,
                            input bit undef_end);
        int first_entry;
        make_program(undef_end);
        run_model(int'(nw));
        first_entry = log_addr.size();
        @(posedge clk);
        start <= 1'b1;
        num_warps <= nw;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        if (done) begin
            $display("Start of test %s was not accepted, done stayed high", name);
            other_errors++;
        end
        while (!done) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        check_results(name, int'(nw), first_entry);
    endtask

    task automatic print_counts(input int extra_other);
        $display("Error counts: %0d wrong values, %0d other failures",
                 value_errors, other_errors + extra_other);
    endtask

    initial begin
        logic [31:0] r;
        gpu_core_pkg::warp_count_t partial;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        run_test("full", 3'd4, 1'b0);
        r = $random(seed);
        partial = {1'b0, r[1:0]};
        if (partial == 3'd0) begin
            partial = 3'd1;
        end
        run_test("partial", partial, 1'b0);
        run_test("undefined_op", 3'd4, 1'b1);
        run_test("restart", 3'd4, 1'b0);
        print_counts(0);
        if (value_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        print_counts(1);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
gpu_isa_pkg.sv
gpu_core_pkg.sv
gpu_interfaces.sv
instruction_decoder.sv
instruction_fetcher.sv
warp_scheduler.sv
thread_lane.sv
store_drain.sv
gpu_core.sv
gpu_core_props.sv
gpu_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= gpu_core_tb
FLAGS ?= --assert --timing

.PHONY: sim clean

# Build and run, status follows the pass message in the output
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Done: no errors" > /dev/null

clean:
	rm -rf obj_dir
